// ==== compile.f ====
+incdir+design
design/store_queue_pkg.sv
design/rr_arbiter.sv
design/l1_store_queue.sv
design/l2_request_port.sv
design/store_path_top.sv
testbench/store_path_tb.sv

// ==== testbench/store_path_tb.sv ====
// Store path testbench
`timescale 1ns/1ns
`include "store_queue_defines.svh"

module store_path_tb
	import store_queue_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int NUM_ROWS = 49;
	localparam int MAX_ACK_DELAY = 7;
	localparam int SEND_WAIT_LIMIT = 16;
	localparam int WATCHDOG_CYCLES = NUM_ROWS * (MAX_ACK_DELAY + SEND_WAIT_LIMIT + 2) + 20;

	// Bytes 0 to 3 from the first store and 4 to 11 from the combined one
	localparam line_data_t MERGED_DATA = {32'h0, {8{8'hbb}}, {4{8'haa}}};

	typedef enum logic [3:0] {
		OP_STORE, OP_FLUSH, OP_IINVALIDATE, OP_DINVALIDATE, OP_MEMBAR,
		OP_LOOKUP, OP_SEND, OP_SEND_NOW, OP_RESPOND, OP_NO_REQUEST
	} op_t;

	// Stores use flags bit 0 as the synchronized flag and bit 1 as the expected success
	// Sends expect flags {synchronized, flush, iinvalidate, dinvalidate}
	// Responses carry sync_success in flags bit 0
	typedef struct packed {
		op_t op;
		thread_idx_t thread;
		logic [31:0] addr;
		line_mask_t mask;
		line_data_t data;
		logic [3:0] flags;
		logic expect_bit;
	} row_t;

	logic clk;
	logic reset;
	sq_request_t request;
	sq_bypass_t bypass_lookup;
	line_mask_t bypass_mask;
	line_data_t bypass_data;
	logic sync_success;
	logic rollback_en;
	thread_bitmap_t wake_bitmap;
	logic l2_request_valid;
	l2_request_t l2_request;
	logic l2_request_ack;
	l2_response_t l2_response;

	row_t rows [NUM_ROWS];
	logic [31:0] lfsr_state;
	int error_count;
	int check_count;

	store_path_top uut(
		.clk(clk),
		.reset(reset),
		.request(request),
		.bypass_lookup(bypass_lookup),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data),
		.sync_success(sync_success),
		.rollback_en(rollback_en),
		.wake_bitmap(wake_bitmap),
		.l2_request_valid(l2_request_valid),
		.l2_request(l2_request),
		.l2_request_ack(l2_request_ack),
		.l2_response(l2_response)
	);

	initial
	begin
		clk = 1'b0;
		forever #(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic check_value(input string name, input logic [127:0] actual,
		input logic [127:0] expected);
		check_count++;
		if (actual !== expected)
		begin
			error_count++;
			$display("** Error at %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
		end
	endtask

	// Byte enables widened to one bit per data bit
	function automatic line_data_t byte_enables(input line_mask_t mask);
		line_data_t enables;
		for (int b = 0; b < `SQ_LINE_BYTES; b++)
			enables[b * 8+:8] = {8{mask[b]}};
		return enables;
	endfunction

	function automatic logic [31:0] lfsr_next(input logic [31:0] state);
		return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
	endfunction

	task automatic draw_ack_delay(output int delay);
		delay = 0;
		for (int i = 0; i < 3; i++)
		begin
			delay = (delay << 1) | int'(lfsr_state[0]);
			lfsr_state = lfsr_next(lfsr_state);
		end
	endtask

	task automatic issue_request(input row_t r);
		request = '0;
		request.thread = r.thread;
		request.address = line_addr_t'(r.addr);
		request.mask = r.mask;
		request.data = r.data;
		request.synchronized = r.flags[0] && r.op == OP_STORE;
		request.store_en = r.op == OP_STORE;
		request.flush_en = r.op == OP_FLUSH;
		request.iinvalidate_en = r.op == OP_IINVALIDATE;
		request.dinvalidate_en = r.op == OP_DINVALIDATE;
		request.membar_en = r.op == OP_MEMBAR;
		@(negedge clk);
		request = '0;
		check_value("rollback_en", 128'(rollback_en), 128'(r.expect_bit));
		// A restarted synchronized store reports the saved L2 result
		if (r.op == OP_STORE && r.flags[0] && !r.expect_bit)
			check_value("sync_success", 128'(sync_success), 128'(r.flags[1]));
	endtask

	task automatic lookup_bypass(input row_t r);
		line_data_t keep;
		bypass_lookup.address = line_addr_t'(r.addr);
		bypass_lookup.thread = r.thread;
		@(negedge clk);
		check_value("bypass_mask", 128'(bypass_mask), 128'(r.mask));
		// A miss or a cache control entry forwards no data at all
		if (r.mask == '0)
			check_value("bypass_data", bypass_data, r.data);
		else
		begin
			keep = byte_enables(r.mask);
			check_value("bypass_data", bypass_data & keep, r.data & keep);
		end
	endtask

	// Behavioral L2 that takes the held request after a delay
	task automatic serve_request(input row_t r, input logic random_delay);
		int waited;
		int delay;
		line_data_t keep;
		waited = 0;
		while (!l2_request_valid && waited < SEND_WAIT_LIMIT)
		begin
			@(negedge clk);
			waited++;
		end
		if (!l2_request_valid)
		begin
			error_count++;
			$display("Error at %0t ns: no L2 request arrived for thread %0d", $time, r.thread);
		end
		else
		begin
			delay = 0;
			if (random_delay)
				draw_ack_delay(delay);
			repeat (delay) @(negedge clk);
			keep = byte_enables(r.mask);
			check_value("l2_request.address", 128'(l2_request.address), 128'(r.addr));
			check_value("l2_request.idx", 128'(l2_request.idx), 128'(r.thread));
			check_value("l2_request.mask", 128'(l2_request.mask), 128'(r.mask));
			// Cache control requests carry no data
			if (r.mask != '0)
				check_value("l2_request.data", l2_request.data & keep, r.data & keep);
			check_value("l2_request flags", 128'({l2_request.synchronized, l2_request.flush,
				l2_request.iinvalidate, l2_request.dinvalidate}), 128'(r.flags));
			l2_request_ack = 1'b1;
			@(negedge clk);
			l2_request_ack = 1'b0;
		end
	endtask

	task automatic give_response(input row_t r);
		l2_response.valid = 1'b1;
		l2_response.idx = r.thread;
		l2_response.sync_success = r.flags[0];
		#(CLK_PERIOD / 4);
		check_value("wake_bitmap", 128'(wake_bitmap),
			128'(thread_bitmap_t'(r.expect_bit) << r.thread));
		@(negedge clk);
		l2_response = '0;
	endtask

	task automatic apply_row(input row_t r);
		case (r.op)
			OP_LOOKUP: lookup_bypass(r);
			OP_SEND: serve_request(r, 1'b1);
			OP_SEND_NOW: serve_request(r, 1'b0);
			OP_RESPOND: give_response(r);
			OP_NO_REQUEST: check_value("l2_request_valid", 128'(l2_request_valid), 128'(0));
			default: issue_request(r);
		endcase
	endtask

	initial
	begin
		reset = 1'b1;
		request = '0;
		bypass_lookup = '0;
		l2_request_ack = 1'b0;
		l2_response = '0;
		lfsr_state = 32'd72742;
		error_count = 0;
		check_count = 0;

		// op, thread, address, mask, data, flags, expected rollback or wake bit
		rows = '{
			'{OP_STORE, 2'd0, 32'h1000_0040, 16'h000f, {16{8'h10}}, 4'h0, 1'b0},
			'{OP_LOOKUP, 2'd0, 32'h1000_0048, 16'h000f, {16{8'h10}}, 4'h0, 1'b0},
			'{OP_LOOKUP, 2'd0, 32'h2000_0040, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_SEND, 2'd0, 32'h1000_0040, 16'h000f, {16{8'h10}}, 4'h0, 1'b0},
			'{OP_RESPOND, 2'd0, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_FLUSH, 2'd1, 32'h3000_0080, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_LOOKUP, 2'd1, 32'h3000_0080, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_SEND, 2'd1, 32'h3000_0080, 16'h0000, '0, 4'h4, 1'b0},
			'{OP_RESPOND, 2'd1, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			// Thread 2 holds the port so thread 3 can combine
			'{OP_STORE, 2'd2, 32'h4000_0000, 16'hffff, {16{8'h22}}, 4'h0, 1'b0},
			'{OP_STORE, 2'd3, 32'h5000_0010, 16'h00ff, {16{8'haa}}, 4'h0, 1'b0},
			'{OP_STORE, 2'd3, 32'h5000_0014, 16'h0ff0, {16{8'hbb}}, 4'h0, 1'b0},
			'{OP_LOOKUP, 2'd3, 32'h5000_0010, 16'h0fff, MERGED_DATA, 4'h0, 1'b0},
			'{OP_SEND, 2'd2, 32'h4000_0000, 16'hffff, {16{8'h22}}, 4'h0, 1'b0},
			'{OP_SEND, 2'd3, 32'h5000_0010, 16'h0fff, MERGED_DATA, 4'h0, 1'b0},
			'{OP_NO_REQUEST, 2'd0, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_RESPOND, 2'd2, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_RESPOND, 2'd3, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_STORE, 2'd1, 32'h6000_0020, 16'h00f0, {16{8'h61}}, 4'h0, 1'b0},
			'{OP_STORE, 2'd1, 32'h7000_0020, 16'h0f00, {16{8'h71}}, 4'h0, 1'b1},
			'{OP_SEND, 2'd1, 32'h6000_0020, 16'h00f0, {16{8'h61}}, 4'h0, 1'b0},
			'{OP_RESPOND, 2'd1, 32'h0, 16'h0000, '0, 4'h0, 1'b1},
			'{OP_STORE, 2'd1, 32'h7000_0020, 16'h0f00, {16{8'h71}}, 4'h0, 1'b0},
			'{OP_SEND, 2'd1, 32'h7000_0020, 16'h0f00, {16{8'h71}}, 4'h0, 1'b0},
			'{OP_RESPOND, 2'd1, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_STORE, 2'd2, 32'h8000_0030, 16'h000f, {16{8'h81}}, 4'h1, 1'b1},
			'{OP_SEND, 2'd2, 32'h8000_0030, 16'h000f, {16{8'h81}}, 4'h8, 1'b0},
			'{OP_RESPOND, 2'd2, 32'h0, 16'h0000, '0, 4'h1, 1'b1},
			'{OP_STORE, 2'd2, 32'h8000_0030, 16'h000f, {16{8'h81}}, 4'h3, 1'b0},
			'{OP_STORE, 2'd0, 32'h9000_0000, 16'hffff, {16{8'h91}}, 4'h1, 1'b1},
			'{OP_SEND, 2'd0, 32'h9000_0000, 16'hffff, {16{8'h91}}, 4'h8, 1'b0},
			'{OP_RESPOND, 2'd0, 32'h0, 16'h0000, '0, 4'h0, 1'b1},
			'{OP_STORE, 2'd0, 32'h9000_0000, 16'hffff, {16{8'h91}}, 4'h1, 1'b0},
			'{OP_MEMBAR, 2'd3, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_IINVALIDATE, 2'd3, 32'ha000_0040, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_MEMBAR, 2'd3, 32'h0, 16'h0000, '0, 4'h0, 1'b1},
			'{OP_SEND, 2'd3, 32'ha000_0040, 16'h0000, '0, 4'h2, 1'b0},
			'{OP_RESPOND, 2'd3, 32'h0, 16'h0000, '0, 4'h0, 1'b1},
			'{OP_DINVALIDATE, 2'd0, 32'hb000_0000, 16'h0000, '0, 4'h0, 1'b0},
			'{OP_SEND, 2'd0, 32'hb000_0000, 16'h0000, '0, 4'h1, 1'b0},
			'{OP_RESPOND, 2'd0, 32'h0, 16'h0000, '0, 4'h0, 1'b0},
			// Pointer sits at thread 1 here, so thread 2 leaves first and the rest wrap
			'{OP_STORE, 2'd2, 32'hc000_0000, 16'hffff, {16{8'hc2}}, 4'h0, 1'b0},
			'{OP_STORE, 2'd3, 32'hc000_0010, 16'hffff, {16{8'hc3}}, 4'h0, 1'b0},
			'{OP_STORE, 2'd0, 32'hc000_0020, 16'hffff, {16{8'hc0}}, 4'h0, 1'b0},
			'{OP_STORE, 2'd1, 32'hc000_0030, 16'hffff, {16{8'hc1}}, 4'h0, 1'b0},
			'{OP_SEND_NOW, 2'd2, 32'hc000_0000, 16'hffff, {16{8'hc2}}, 4'h0, 1'b0},
			'{OP_SEND_NOW, 2'd3, 32'hc000_0010, 16'hffff, {16{8'hc3}}, 4'h0, 1'b0},
			'{OP_SEND_NOW, 2'd0, 32'hc000_0020, 16'hffff, {16{8'hc0}}, 4'h0, 1'b0},
			'{OP_SEND_NOW, 2'd1, 32'hc000_0030, 16'hffff, {16{8'hc1}}, 4'h0, 1'b0}
		};

		repeat (4) @(negedge clk);
		reset = 1'b0;
		check_value("rollback_en", 128'(rollback_en), 128'(0));
		check_value("l2_request_valid", 128'(l2_request_valid), 128'(0));
		check_value("wake_bitmap", 128'(wake_bitmap), 128'(0));
		check_value("bypass_mask", 128'(bypass_mask), 128'(0));
		check_value("sync_success", 128'(sync_success), 128'(0));

		for (int i = 0; i < NUM_ROWS; i++)
			apply_row(rows[i]);

		@(negedge clk);
		$display("Checks run: %0d, errors: %0d", check_count, error_count);
		if (error_count == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

	// Bounds the run by the worst case of every row waiting its longest
	initial
	begin
		repeat (WATCHDOG_CYCLES) @(posedge clk);
		$display("Watchdog expired after %0d cycles, the run did not finish", WATCHDOG_CYCLES);
		$display("Checks run: %0d, errors: %0d", check_count, error_count + 1);
		$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// ==== design/store_path_top.sv ====
// L1 store path top level
`timescale 1ns/1ns

module store_path_top
	import store_queue_pkg::*;
(
	input logic clk,
	input logic reset,

	// Data cache stage
	input sq_request_t request,
	input sq_bypass_t bypass_lookup,
	output line_mask_t bypass_mask,
	output line_data_t bypass_data,
	output logic sync_success,
	output logic rollback_en,
	output thread_bitmap_t wake_bitmap,

	// L2 interconnect
	output logic l2_request_valid,
	output l2_request_t l2_request,
	input logic l2_request_ack,
	input l2_response_t l2_response
);

	logic dequeue_ready;
	logic dequeue_ack;
	l2_request_t dequeue_request;

	l1_store_queue store_queue(
		.clk(clk),
		.reset(reset),
		.request(request),
		.bypass_lookup(bypass_lookup),
		.bypass_mask(bypass_mask),
		.bypass_data(bypass_data),
		.sync_success(sync_success),
		.rollback_en(rollback_en),
		.wake_bitmap(wake_bitmap),
		.dequeue_ready(dequeue_ready),
		.dequeue_request(dequeue_request),
		.dequeue_ack(dequeue_ack),
		.l2_response(l2_response)
	);

	l2_request_port request_port(
		.clk(clk),
		.reset(reset),
		.dequeue_ready(dequeue_ready),
		.dequeue_request(dequeue_request),
		.dequeue_ack(dequeue_ack),
		.l2_request_valid(l2_request_valid),
		.l2_request(l2_request),
		.l2_request_ack(l2_request_ack)
	);

endmodule

// ==== design/l2_request_port.sv ====
// L2 request output register
`timescale 1ns/1ns

module l2_request_port
	import store_queue_pkg::*;
(
	input logic clk,
	input logic reset,

	// From the store queue
	input logic dequeue_ready,
	input l2_request_t dequeue_request,
	output logic dequeue_ack,

	// To the L2 interconnect
	output logic l2_request_valid,
	output l2_request_t l2_request,
	input logic l2_request_ack
);

	logic buffer_emptying;
	logic latch_en;

	// The held request leaves at this edge
	assign buffer_emptying = l2_request_valid && l2_request_ack;

	// Room exists when the buffer is empty or drains this cycle
	assign dequeue_ack = !l2_request_valid || buffer_emptying;
	assign latch_en = dequeue_ready && dequeue_ack;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			l2_request_valid <= 1'b0;
		else if (latch_en)
			l2_request_valid <= 1'b1;
		else if (buffer_emptying)
			l2_request_valid <= 1'b0;
	end

	// Request stays stable until the L2 takes it
	always_ff @(posedge clk)
	begin
		if (latch_en)
			l2_request <= dequeue_request;
	end

endmodule

// ==== design/l1_store_queue.sv ====
// L1 data cache store queue
`timescale 1ns/1ns
`include "store_queue_defines.svh"

module l1_store_queue
	import store_queue_pkg::*;
(
	input logic clk,
	input logic reset,
	input sq_request_t request,
	input sq_bypass_t bypass_lookup,
	output line_mask_t bypass_mask,
	output line_data_t bypass_data,
	output logic sync_success,
	output logic rollback_en,
	output thread_bitmap_t wake_bitmap,
	output logic dequeue_ready,
	output l2_request_t dequeue_request,
	input logic dequeue_ack,
	input l2_response_t l2_response
);

	// Control state of one pending entry
	typedef struct packed {
		logic valid;
		logic synchronized;
		logic flush;
		logic iinvalidate;
		logic dinvalidate;
		logic request_sent;
		logic response_received;
		logic thread_waiting;
		logic sync_success;
	} entry_ctrl_t;

	entry_ctrl_t entry_ctrl[`SQ_THREADS];
	line_addr_t entry_addr[`SQ_THREADS];
	line_mask_t entry_mask[`SQ_THREADS];
	line_data_t entry_data[`SQ_THREADS];

	thread_bitmap_t rollback;
	thread_bitmap_t send_request;
	thread_bitmap_t grant_oh;
	thread_idx_t grant_idx;
	line_addr_t store_line;
	line_addr_t bypass_line;
	logic bypass_hit;

	// Entries are tracked per line so the byte offset is dropped
	assign store_line.tag = request.address.tag;
	assign store_line.set_idx = request.address.set_idx;
	assign store_line.offset = '0;
	assign bypass_line.tag = bypass_lookup.address.tag;
	assign bypass_line.set_idx = bypass_lookup.address.set_idx;
	assign bypass_line.offset = '0;

	rr_arbiter send_arbiter(
		.clk(clk),
		.reset(reset),
		.request(send_request),
		.advance(dequeue_ready && dequeue_ack),
		.grant_oh(grant_oh),
		.grant_idx(grant_idx)
	);

	genvar t;
	generate
		for (t = 0; t < `SQ_THREADS; t++)
		begin : entry_gen
			logic this_thread;
			logic store_req;
			logic membar_req;
			logic control_req;
			logic send_now;
			logic got_response;
			logic restarted_sync;
			logic can_combine;
			logic new_store;
			logic new_control;

			assign this_thread = request.thread == thread_idx_t'(t);
			assign store_req = request.store_en && this_thread;
			assign membar_req = request.membar_en && this_thread;
			assign control_req = this_thread
				&& (request.flush_en || request.iinvalidate_en || request.dinvalidate_en);
			assign send_now = grant_oh[t] && dequeue_ack;
			assign got_response = l2_response.valid && l2_response.idx == thread_idx_t'(t);
			assign restarted_sync = entry_ctrl[t].valid && entry_ctrl[t].response_received
				&& entry_ctrl[t].synchronized;

			// Only plain stores to a line still waiting to leave can merge
			assign can_combine = request.store_en
				&& entry_ctrl[t].valid
				&& !entry_ctrl[t].request_sent
				&& !send_now
				&& !entry_ctrl[t].synchronized
				&& !entry_ctrl[t].flush
				&& !entry_ctrl[t].iinvalidate
				&& !entry_ctrl[t].dinvalidate
				&& !request.synchronized
				&& entry_addr[t] == store_line;

			assign new_store = store_req && !restarted_sync
				&& (!entry_ctrl[t].valid || can_combine || got_response);
			assign new_control = control_req && (!entry_ctrl[t].valid || got_response);

			assign send_request[t] = entry_ctrl[t].valid && !entry_ctrl[t].request_sent;
			assign wake_bitmap[t] = got_response && entry_ctrl[t].thread_waiting;

			always_comb
			begin
				rollback[t] = 1'b0;
				if (store_req || control_req)
				begin
					// A first synchronized store waits for its L2 result even with room
					if (request.synchronized)
						rollback[t] = !restarted_sync;
					else if (entry_ctrl[t].valid && !can_combine && !got_response)
						rollback[t] = 1'b1;
				end
				else if (membar_req && entry_ctrl[t].valid && !got_response)
					rollback[t] = 1'b1;
			end

			always_ff @(posedge clk, posedge reset)
			begin
				if (reset)
					entry_ctrl[t] <= '0;
				else
				begin
					if (send_now)
						entry_ctrl[t].request_sent <= 1'b1;

					if (wake_bitmap[t])
						entry_ctrl[t].thread_waiting <= 1'b0;
					else if (rollback[t])
						entry_ctrl[t].thread_waiting <= 1'b1;

					if (store_req && restarted_sync)
					begin
						// The restarted instruction collects the result and frees the entry
						entry_ctrl[t].valid <= 1'b0;
					end
					else if (new_store && !can_combine)
					begin
						entry_ctrl[t].valid <= 1'b1;
						entry_ctrl[t].synchronized <= request.synchronized;
						entry_ctrl[t].flush <= 1'b0;
						entry_ctrl[t].iinvalidate <= 1'b0;
						entry_ctrl[t].dinvalidate <= 1'b0;
						entry_ctrl[t].request_sent <= 1'b0;
						entry_ctrl[t].response_received <= 1'b0;
					end
					else if (new_control)
					begin
						entry_ctrl[t].valid <= 1'b1;
						entry_ctrl[t].synchronized <= 1'b0;
						entry_ctrl[t].flush <= request.flush_en;
						entry_ctrl[t].iinvalidate <= request.iinvalidate_en;
						entry_ctrl[t].dinvalidate <= request.dinvalidate_en;
						entry_ctrl[t].request_sent <= 1'b0;
						entry_ctrl[t].response_received <= 1'b0;
					end

					// A response retires the entry unless a new one replaces it now
					if (got_response && !new_store && !new_control)
					begin
						if (entry_ctrl[t].synchronized)
						begin
							entry_ctrl[t].response_received <= 1'b1;
							entry_ctrl[t].sync_success <= l2_response.sync_success;
						end
						else
							entry_ctrl[t].valid <= 1'b0;
					end
				end
			end

			always_ff @(posedge clk)
			begin
				if (new_store)
				begin
					// Later bytes overwrite earlier ones only where the new mask is set
					for (int b = 0; b < `SQ_LINE_BYTES; b++)
						if (request.mask[b])
							entry_data[t][b * 8+:8] <= request.data[b * 8+:8];
					entry_mask[t] <= can_combine ? (entry_mask[t] | request.mask) : request.mask;
					entry_addr[t] <= store_line;
				end
				else if (new_control)
				begin
					entry_mask[t] <= '0;
					entry_addr[t] <= store_line;
				end
			end
		end
	endgenerate

	assign dequeue_ready = |grant_oh;
	assign dequeue_request.address = entry_addr[grant_idx];
	assign dequeue_request.idx = grant_idx;
	assign dequeue_request.mask = entry_mask[grant_idx];
	assign dequeue_request.data = entry_data[grant_idx];
	assign dequeue_request.synchronized = entry_ctrl[grant_idx].synchronized;
	assign dequeue_request.flush = entry_ctrl[grant_idx].flush;
	assign dequeue_request.iinvalidate = entry_ctrl[grant_idx].iinvalidate;
	assign dequeue_request.dinvalidate = entry_ctrl[grant_idx].dinvalidate;

	// Cache control entries carry no data to forward
	assign bypass_hit = entry_ctrl[bypass_lookup.thread].valid
		&& !entry_ctrl[bypass_lookup.thread].flush
		&& !entry_ctrl[bypass_lookup.thread].iinvalidate
		&& !entry_ctrl[bypass_lookup.thread].dinvalidate
		&& entry_addr[bypass_lookup.thread] == bypass_line;

	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
		begin
			bypass_mask <= '0;
			sync_success <= 1'b0;
			rollback_en <= 1'b0;
		end
		else
		begin
			bypass_mask <= bypass_hit ? entry_mask[bypass_lookup.thread] : '0;
			sync_success <= entry_ctrl[request.thread].sync_success;
			rollback_en <= |rollback;
		end
	end

	always_ff @(posedge clk)
		bypass_data <= bypass_hit ? entry_data[bypass_lookup.thread] : '0;

endmodule

// ==== design/rr_arbiter.sv ====
// Round-robin arbiter
`timescale 1ns/1ns
`include "store_queue_defines.svh"

module rr_arbiter
	import store_queue_pkg::*;
(
	input logic clk,
	input logic reset,
	input thread_bitmap_t request,
	input logic advance,
	output thread_bitmap_t grant_oh,
	output thread_idx_t grant_idx
);

	// Requester with the highest priority this cycle
	thread_idx_t priority_ptr;
	thread_idx_t candidate;
	logic found;

	// Scan from the pointer and take the first requester
	always_comb
	begin
		grant_oh = '0;
		found = 1'b0;
		candidate = '0;
		for (int i = 0; i < `SQ_THREADS; i++)
		begin
			candidate = thread_idx_t'((int'(priority_ptr) + i) % `SQ_THREADS);
			if (!found && request[candidate])
			begin
				found = 1'b1;
				grant_oh[candidate] = 1'b1;
			end
		end
	end

	always_comb
	begin
		grant_idx = '0;
		for (int i = 0; i < `SQ_THREADS; i++)
			if (grant_oh[i])
				grant_idx = grant_idx | thread_idx_t'(i);
	end

	// The winner drops to lowest priority once its request is taken
	always_ff @(posedge clk, posedge reset)
	begin
		if (reset)
			priority_ptr <= '0;
		else if (advance && |request)
			priority_ptr <= (grant_idx == thread_idx_t'(`SQ_THREADS - 1)) ? '0 : grant_idx + 1'b1;
	end

endmodule

// ==== design/store_queue_pkg.sv ====
// Store path shared types
`include "store_queue_defines.svh"

package store_queue_pkg;

	// Address split for a 64 set cache
	localparam int OFFSET_WIDTH = $clog2(`SQ_LINE_BYTES);
	localparam int SET_IDX_WIDTH = 6;
	localparam int TAG_WIDTH = `SQ_ADDR_WIDTH - SET_IDX_WIDTH - OFFSET_WIDTH;

	typedef logic [$clog2(`SQ_THREADS) - 1:0] thread_idx_t;
	typedef logic [`SQ_THREADS - 1:0] thread_bitmap_t;
	typedef logic [`SQ_LINE_BYTES * 8 - 1:0] line_data_t;
	typedef logic [`SQ_LINE_BYTES - 1:0] line_mask_t;

	typedef struct packed {
		logic [TAG_WIDTH - 1:0] tag;
		logic [SET_IDX_WIDTH - 1:0] set_idx;
		logic [OFFSET_WIDTH - 1:0] offset;
	} line_addr_t;

	// Operation issued by the data cache stage with at most one strobe per cycle
	typedef struct packed {
		logic store_en;
		logic flush_en;
		logic membar_en;
		logic iinvalidate_en;
		logic dinvalidate_en;
		line_addr_t address;
		line_mask_t mask;
		line_data_t data;
		logic synchronized;
		thread_idx_t thread;
	} sq_request_t;

	typedef struct packed {
		line_addr_t address;
		thread_idx_t thread;
	} sq_bypass_t;

	typedef struct packed {
		line_addr_t address;
		thread_idx_t idx;
		line_mask_t mask;
		line_data_t data;
		logic synchronized;
		logic flush;
		logic iinvalidate;
		logic dinvalidate;
	} l2_request_t;

	typedef struct packed {
		logic valid;
		thread_idx_t idx;
		logic sync_success;
	} l2_response_t;

endpackage

// ==== design/store_queue_defines.svh ====
// Store queue build constants
`ifndef STORE_QUEUE_DEFINES_SVH
`define STORE_QUEUE_DEFINES_SVH

// Hardware threads sharing the core with one store entry each
`define SQ_THREADS 4

// Bytes in one L1 data cache line
`define SQ_LINE_BYTES 16

// Width of a physical address
`define SQ_ADDR_WIDTH 32

`endif
